// File: Makefile
# Verilator build and run of the clock monitor testbench

all: run

# rebuilt only when a source or the file list changes
obj_dir/Vclk_mon_tb: clk_mon.f $(wildcard hdl/*.sv) $(wildcard verification/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module clk_mon_tb -f clk_mon.f

# pass is decided by the pass line in the output
run: obj_dir/Vclk_mon_tb
	@out="$$(./obj_dir/Vclk_mon_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation completed successfully"

clean:
	rm -rf obj_dir

.PHONY: all run clean

// File: clk_mon.f
hdl/clk_mon_pkg.sv
hdl/clk_ratio_counter.sv
hdl/clk_range_check.sv
hdl/clk_mon_regs.sv
hdl/clk_mon_top.sv
verification/clk_mon_checker.sv
verification/clk_mon_tb.sv

// File: hdl/clk_mon_pkg.sv
// clock monitor shared definitions
// data widths, register map and core version

`default_nettype none

package clk_mon_pkg;

  // ********************************************************************
  // data types
  // ********************************************************************

  // device cycles counted over one window
  typedef logic [31:0] count_t;

  // register bus address and data
  typedef logic [7:0]  reg_addr_t;
  typedef logic [31:0] reg_data_t;

  // sticky status per channel, bit 0 upwards
  typedef logic [2:0]  flag_t;

  // bit positions inside flag_t
  localparam int FLAG_TOO_SLOW   = 0;
  localparam int FLAG_TOO_FAST   = 1;
  localparam int FLAG_CLOCK_LOST = 2;

  // ********************************************************************
  // register map
  // ********************************************************************

  localparam reg_addr_t ADDR_VERSION     = 8'h00;
  // one status word per channel, write ones to clear
  localparam reg_addr_t ADDR_STATUS_BASE = 8'h04;
  // measured counts, read only
  localparam reg_addr_t ADDR_COUNT_BASE  = 8'h10;
  // limits, read write
  localparam reg_addr_t ADDR_MIN_BASE    = 8'h20;
  localparam reg_addr_t ADDR_MAX_BASE    = 8'h30;

  // major.minor.patch packed as 16.8.8
  localparam reg_data_t CORE_VERSION     = 32'h0001_0000;

endpackage

`default_nettype wire

// File: hdl/clk_mon_regs.sv
// clock monitor register bank
// limits, counts and write-one-to-clear status on a strobe bus

`timescale 1ns/1ps
`default_nettype none

module clk_mon_regs #(
  parameter int NUM_CLKS = 2
) (
  input  wire                        up_clk,
  input  wire                        up_rst,

  // write bus
  input  wire                        up_wreq,
  input  wire clk_mon_pkg::reg_addr_t up_waddr,
  input  wire clk_mon_pkg::reg_data_t up_wdata,
  output logic                       up_wack,

  // read bus
  input  wire                        up_rreq,
  input  wire clk_mon_pkg::reg_addr_t up_raddr,
  output clk_mon_pkg::reg_data_t     up_rdata,
  output logic                       up_rack,

  // per channel
  input  wire clk_mon_pkg::count_t [NUM_CLKS-1:0] counts,
  input  wire clk_mon_pkg::flag_t  [NUM_CLKS-1:0] flags,
  output clk_mon_pkg::count_t      [NUM_CLKS-1:0] min_limits,
  output clk_mon_pkg::count_t      [NUM_CLKS-1:0] max_limits,
  output clk_mon_pkg::flag_t       [NUM_CLKS-1:0] flag_clear
);

  // read data before the output register
  clk_mon_pkg::reg_data_t rd_mux;

  // ********************************************************************
  // write side
  // ********************************************************************

  // status clear acts in the write cycle itself
  always_comb begin
    flag_clear = '0;
    for (int i = 0; i < NUM_CLKS; i++) begin
      if (up_wreq &&
          (up_waddr == clk_mon_pkg::reg_addr_t'(clk_mon_pkg::ADDR_STATUS_BASE + i))) begin
        flag_clear[i] = up_wdata[$bits(clk_mon_pkg::flag_t)-1:0];
      end
    end
  end

  always_ff @(posedge up_clk or posedge up_rst) begin
    if (up_rst) begin
      up_wack <= 1'b0;
      // open limits, no range flag until programmed
      min_limits <= '0;
      max_limits <= '1;
    end else begin
      // every write is acked, known address or not
      up_wack <= up_wreq;
      for (int i = 0; i < NUM_CLKS; i++) begin
        if (up_wreq &&
            (up_waddr == clk_mon_pkg::reg_addr_t'(clk_mon_pkg::ADDR_MIN_BASE + i))) begin
          min_limits[i] <= up_wdata;
        end
        if (up_wreq &&
            (up_waddr == clk_mon_pkg::reg_addr_t'(clk_mon_pkg::ADDR_MAX_BASE + i))) begin
          max_limits[i] <= up_wdata;
        end
      end
    end
  end

  // ********************************************************************
  // read side
  // ********************************************************************

  // unknown addresses fall through as zero
  always_comb begin
    rd_mux = '0;
    if (up_raddr == clk_mon_pkg::ADDR_VERSION) begin
      rd_mux = clk_mon_pkg::CORE_VERSION;
    end
    for (int i = 0; i < NUM_CLKS; i++) begin
      if (up_raddr == clk_mon_pkg::reg_addr_t'(clk_mon_pkg::ADDR_STATUS_BASE + i)) begin
        rd_mux = clk_mon_pkg::reg_data_t'(flags[i]);
      end
      if (up_raddr == clk_mon_pkg::reg_addr_t'(clk_mon_pkg::ADDR_COUNT_BASE + i)) begin
        rd_mux = counts[i];
      end
      if (up_raddr == clk_mon_pkg::reg_addr_t'(clk_mon_pkg::ADDR_MIN_BASE + i)) begin
        rd_mux = min_limits[i];
      end
      if (up_raddr == clk_mon_pkg::reg_addr_t'(clk_mon_pkg::ADDR_MAX_BASE + i)) begin
        rd_mux = max_limits[i];
      end
    end
  end

  always_ff @(posedge up_clk or posedge up_rst) begin
    if (up_rst) begin
      up_rack  <= 1'b0;
      up_rdata <= '0;
    end else begin
      up_rack <= up_rreq;
      // data only valid with the ack, zero otherwise
      up_rdata <= up_rreq ? rd_mux : '0;
    end
  end

  // ********************************************************************
  // checks
  // ********************************************************************

  // fixed one cycle read turnaround, no back pressure
  a_rack_follows: assert property (
    @(posedge up_clk) disable iff (up_rst)
    up_rreq |=> up_rack
  ) else $error("read request without ack one cycle later");

endmodule

`default_nettype wire

// File: hdl/clk_mon_top.sv
// multi channel clock frequency monitor
// per channel counters and checkers behind one register bank

`timescale 1ns/1ps
`default_nettype none

module clk_mon_top #(
  parameter int NUM_CLKS     = 2,
  parameter int WINDOW_BITS  = 16,
  parameter int LOST_WINDOWS = 4
) (
  // processor clock and reset
  input  wire                         up_clk,
  input  wire                         up_rst,

  // monitored clocks, one reset each
  input  wire  [NUM_CLKS-1:0]         d_clk,
  input  wire  [NUM_CLKS-1:0]         d_rst,

  // write bus
  input  wire                         up_wreq,
  input  wire clk_mon_pkg::reg_addr_t up_waddr,
  input  wire clk_mon_pkg::reg_data_t up_wdata,
  output logic                        up_wack,

  // read bus
  input  wire                         up_rreq,
  input  wire clk_mon_pkg::reg_addr_t up_raddr,
  output clk_mon_pkg::reg_data_t      up_rdata,
  output logic                        up_rack
);

  // per channel wiring
  clk_mon_pkg::count_t [NUM_CLKS-1:0] counts;
  logic                [NUM_CLKS-1:0] count_update;
  logic                [NUM_CLKS-1:0] window_tick;
  clk_mon_pkg::count_t [NUM_CLKS-1:0] min_limits;
  clk_mon_pkg::count_t [NUM_CLKS-1:0] max_limits;
  clk_mon_pkg::flag_t  [NUM_CLKS-1:0] flags;
  clk_mon_pkg::flag_t  [NUM_CLKS-1:0] flag_clear;

  // ********************************************************************
  // channels
  // ********************************************************************

  for (genvar i = 0; i < NUM_CLKS; i++) begin : g_chan
    // each channel keeps its own window
    clk_ratio_counter #(
      .WINDOW_BITS (WINDOW_BITS)
    ) i_counter (
      .up_clk       (up_clk),
      .up_rst       (up_rst),
      .count        (counts[i]),
      .count_update (count_update[i]),
      .window_tick  (window_tick[i]),
      .d_clk        (d_clk[i]),
      .d_rst        (d_rst[i])
    );

    clk_range_check #(
      .LOST_WINDOWS (LOST_WINDOWS)
    ) i_check (
      .up_clk       (up_clk),
      .up_rst       (up_rst),
      .count        (counts[i]),
      .count_update (count_update[i]),
      .window_tick  (window_tick[i]),
      .min_limit    (min_limits[i]),
      .max_limit    (max_limits[i]),
      .flag_clear   (flag_clear[i]),
      .flags        (flags[i])
    );
  end

  // register access
  clk_mon_regs #(
    .NUM_CLKS (NUM_CLKS)
  ) i_regs (
    .up_clk     (up_clk),
    .up_rst     (up_rst),
    .up_wreq    (up_wreq),
    .up_waddr   (up_waddr),
    .up_wdata   (up_wdata),
    .up_wack    (up_wack),
    .up_rreq    (up_rreq),
    .up_raddr   (up_raddr),
    .up_rdata   (up_rdata),
    .up_rack    (up_rack),
    .counts     (counts),
    .flags      (flags),
    .min_limits (min_limits),
    .max_limits (max_limits),
    .flag_clear (flag_clear)
  );

endmodule

`default_nettype wire

// File: hdl/clk_range_check.sv
// range checker for one channel
// compares fresh counts with the limits and watches for a lost clock

`timescale 1ns/1ps
`default_nettype none

module clk_range_check #(
  parameter int LOST_WINDOWS = 4
) (
  input  wire                  up_clk,
  input  wire                  up_rst,

  // from the ratio counter
  input  wire clk_mon_pkg::count_t count,
  input  wire                  count_update,
  input  wire                  window_tick,

  // from the register bank
  input  wire clk_mon_pkg::count_t min_limit,
  input  wire clk_mon_pkg::count_t max_limit,
  input  wire clk_mon_pkg::flag_t  flag_clear,

  // sticky status
  output clk_mon_pkg::flag_t   flags
);

  // room for the value LOST_WINDOWS itself
  localparam int MISS_W = $clog2(LOST_WINDOWS + 1);

  logic [MISS_W-1:0]   miss_cnt;
  logic                miss_full;
  clk_mon_pkg::flag_t  flag_set;

  // ********************************************************************
  // flag set conditions
  // ********************************************************************

  // one more silent window would reach the limit
  assign miss_full = (miss_cnt >= MISS_W'(LOST_WINDOWS - 1));

  always_comb begin
    flag_set = '0;
    // range flags only on a new count
    flag_set[clk_mon_pkg::FLAG_TOO_SLOW] = count_update && (count < min_limit);
    flag_set[clk_mon_pkg::FLAG_TOO_FAST] = count_update && (count > max_limit);
    // keeps firing each window while the clock stays away
    flag_set[clk_mon_pkg::FLAG_CLOCK_LOST] = window_tick && !count_update && miss_full;
  end

  // ********************************************************************
  // missed window counter and sticky flags
  // ********************************************************************

  always_ff @(posedge up_clk or posedge up_rst) begin
    if (up_rst) begin
      miss_cnt <= '0;
      flags    <= '0;
    end else begin
      // any update proves the clock alive
      if (count_update) begin
        miss_cnt <= '0;
      end else if (window_tick && (miss_cnt != MISS_W'(LOST_WINDOWS))) begin
        miss_cnt <= miss_cnt + 1'b1;
      end
      // set beats clear in the same cycle
      flags <= (flags & ~flag_clear) | flag_set;
    end
  end

  // ********************************************************************
  // checks
  // ********************************************************************

  // limits and counts come from other blocks, none may poison the status
  a_flags_known: assert property (
    @(posedge up_clk) disable iff (up_rst)
    !$isunknown(flags)
  ) else $error("range flags unknown");

endmodule

`default_nettype wire

// File: hdl/clk_ratio_counter.sv
// clock ratio counter for one channel
// counts device cycles per processor window, result handed back by toggle

`timescale 1ns/1ps
`default_nettype none

module clk_ratio_counter #(
  parameter int WINDOW_BITS = 16
) (
  // processor side
  input  wire                  up_clk,
  input  wire                  up_rst,
  output clk_mon_pkg::count_t  count,
  output logic                 count_update,
  output logic                 window_tick,

  // device side
  input  wire                  d_clk,
  input  wire                  d_rst
);

  // count width, one extra bit flags saturation
  localparam int CW = $bits(clk_mon_pkg::count_t);

  // processor domain
  logic [WINDOW_BITS-1:0] win_cnt;
  logic                   win_wrap;
  logic                   win_toggle;
  logic                   ret_toggle_m1;
  logic                   ret_toggle_m2;
  logic                   ret_toggle_m3;
  logic                   up_edge;

  // device domain
  logic                   win_toggle_m1;
  logic                   win_toggle_m2;
  logic                   win_toggle_m3;
  logic                   d_edge;
  logic                   ret_toggle;
  logic [CW:0]            d_count;
  clk_mon_pkg::count_t    d_hold;

  // ********************************************************************
  // processor window and count capture
  // ********************************************************************

  // last cycle of the window
  assign win_wrap = (win_cnt == '1);

  // returned toggle changed, held count is stable by now
  assign up_edge = ret_toggle_m3 ^ ret_toggle_m2;

  always_ff @(posedge up_clk or posedge up_rst) begin
    if (up_rst) begin
      win_cnt       <= '0;
      win_toggle    <= 1'b0;
      window_tick   <= 1'b0;
      ret_toggle_m1 <= 1'b0;
      ret_toggle_m2 <= 1'b0;
      ret_toggle_m3 <= 1'b0;
      count         <= '0;
      count_update  <= 1'b0;
    end else begin
      // free running window counter
      win_cnt     <= win_cnt + 1'b1;
      window_tick <= win_wrap;
      if (win_wrap) begin
        win_toggle <= ~win_toggle;
      end
      // bring the device toggle over
      ret_toggle_m1 <= ret_toggle;
      ret_toggle_m2 <= ret_toggle_m1;
      ret_toggle_m3 <= ret_toggle_m2;
      // d_hold only moves one window later, safe to sample as a bus
      count_update <= up_edge;
      if (up_edge) begin
        count <= d_hold;
      end
    end
  end

  // ********************************************************************
  // device side counter
  // ********************************************************************

  // window boundary seen in the device domain
  assign d_edge = win_toggle_m3 ^ win_toggle_m2;

  always_ff @(posedge d_clk or posedge d_rst) begin
    if (d_rst) begin
      win_toggle_m1 <= 1'b0;
      win_toggle_m2 <= 1'b0;
      win_toggle_m3 <= 1'b0;
      ret_toggle    <= 1'b0;
      d_count       <= '0;
    end else begin
      win_toggle_m1 <= win_toggle;
      win_toggle_m2 <= win_toggle_m1;
      win_toggle_m3 <= win_toggle_m2;
      if (d_edge) begin
        // answer back and restart, this edge is the first of the new window
        ret_toggle <= ~ret_toggle;
        d_count    <= 'd1;
      end else if (!d_count[CW]) begin
        d_count <= d_count + 1'b1;
      end else begin
        // stuck at all ones until the next window
        d_count <= '1;
      end
    end
  end

  // previous window's count, waits here for the processor
  // top bit set means the window overflowed, report all ones
  always_ff @(posedge d_clk) begin
    if (d_edge) begin
      d_hold <= d_count[CW] ? '1 : d_count[CW-1:0];
    end
  end

  // ********************************************************************
  // checks
  // ********************************************************************

  // each capture needs a full round trip, so no back to back updates
  a_update_single: assert property (
    @(posedge up_clk) disable iff (up_rst)
    count_update |=> !count_update
  ) else $error("count_update asserted in two consecutive cycles");

endmodule

`default_nettype wire

// File: verification/clk_mon_checker.sv
// read data checker for the clock monitor
// compares every acknowledged read with the expected range from the testbench

`timescale 1ns/1ps
`default_nettype none

module clk_mon_checker (
  input  wire                         up_clk,
  input  wire                         up_rst,

  // read bus as seen by the DUT
  input  wire                         up_rack,
  input  wire clk_mon_pkg::reg_data_t up_rdata,

  // expectation set with the request
  input  wire  [31:0]                 exp_lo,
  input  wire  [31:0]                 exp_hi,
  input  wire  [127:0]                exp_name,
  input  wire  [7:0]                  exp_id,

  // running totals
  output int                          mismatch_count,
  output int                          read_count
);

  // ********************************************************************
  // compare on the ack cycle
  // ********************************************************************

  always @(posedge up_clk or posedge up_rst) begin
    if (up_rst) begin
      mismatch_count <= 0;
      read_count     <= 0;
    end else if (up_rack) begin
      read_count <= read_count + 1;
      if ($isunknown(up_rdata)) begin
        // undriven data never matches
        mismatch_count <= mismatch_count + 1;
        $display("read data unknown in test %0s (%0d)", exp_name, exp_id);
      end else if ((up_rdata < exp_lo) || (up_rdata > exp_hi)) begin
        mismatch_count <= mismatch_count + 1;
        // exact compare or a window around the nominal count
        if (exp_lo == exp_hi) begin
          $display("MISMATCH %0s (%0d): expected 0x%08h actual 0x%08h",
                   exp_name, exp_id, exp_lo, up_rdata);
        end else begin
          $display("MISMATCH %0s (%0d): expected 0x%08h..0x%08h actual 0x%08h",
                   exp_name, exp_id, exp_lo, exp_hi, up_rdata);
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: verification/clk_mon_stim.txt
// half0 half1 min0 max0 min1 max1 exp0 exp1 tol flags0 flags1, all hex, half periods in ns
// exp of 0 skips the count read, flag bits are clock_lost too_fast too_slow from msb
// both limits bracket the counts
6 2 a0 b4 1f4 208 ab 200 2 0 0
// ch0 min above its count
6 2 c8 ffffffff 1f4 208 ab 200 2 1 0
// both max below the counts
6 2 0 96 0 190 ab 200 2 2 2
// new ratios, bracketed again after the clear
5 3 c3 d7 14b 15f cd 155 2 0 0
// ch0 stopped, ch1 keeps running
0 3 0 ffffffff 14b 15f 0 155 2 4 0

// File: verification/clk_mon_tb.sv
// testbench for the clock frequency monitor
// stim file driven clocks and limits, strobe bus tasks, watchdog

`timescale 1ns/1ps
`default_nettype none

module clk_mon_tb;

  localparam int NUM_CLKS     = 2;
  localparam int WINDOW_BITS  = 8;
  localparam int LOST_WINDOWS = 4;
  localparam int WIN_CYCLES   = 1 << WINDOW_BITS;
  // words per stim row and rows in the file
  localparam int COLS         = 11;
  localparam int NUM_TESTS    = 5;
  // clear well away from window ticks and count updates
  localparam int CLEAR_PHASE  = 64;
  localparam longint WATCHDOG_NS =
    longint'(NUM_TESTS * (LOST_WINDOWS + 4) * WIN_CYCLES * 8) + longint'(4 * WIN_CYCLES * 8);

  logic                   up_clk;
  logic                   up_rst;
  logic                   d_clk0;
  logic                   d_clk1;
  logic [NUM_CLKS-1:0]    d_rst;
  logic                   up_wreq;
  clk_mon_pkg::reg_addr_t up_waddr;
  clk_mon_pkg::reg_data_t up_wdata;
  logic                   up_wack;
  logic                   up_rreq;
  clk_mon_pkg::reg_addr_t up_raddr;
  clk_mon_pkg::reg_data_t up_rdata;
  logic                   up_rack;

  // expectation handed to the checker
  logic [31:0]            exp_lo;
  logic [31:0]            exp_hi;
  logic [127:0]           exp_name;
  logic [7:0]             exp_id;
  int                     mismatches;
  int                     reads_seen;

  logic [31:0]            stim_mem [0:NUM_TESTS*COLS-1];
  int                     half0;
  int                     half1;
  logic [31:0]            lfsr;
  int                     cyc;
  int                     other_errors;

  clk_mon_top #(
    .NUM_CLKS     (NUM_CLKS),
    .WINDOW_BITS  (WINDOW_BITS),
    .LOST_WINDOWS (LOST_WINDOWS)
  ) i_dut (
    .up_clk   (up_clk),
    .up_rst   (up_rst),
    .d_clk    ({d_clk1, d_clk0}),
    .d_rst    (d_rst),
    .up_wreq  (up_wreq),
    .up_waddr (up_waddr),
    .up_wdata (up_wdata),
    .up_wack  (up_wack),
    .up_rreq  (up_rreq),
    .up_raddr (up_raddr),
    .up_rdata (up_rdata),
    .up_rack  (up_rack)
  );

  clk_mon_checker i_checker (
    .up_clk         (up_clk),
    .up_rst         (up_rst),
    .up_rack        (up_rack),
    .up_rdata       (up_rdata),
    .exp_lo         (exp_lo),
    .exp_hi         (exp_hi),
    .exp_name       (exp_name),
    .exp_id         (exp_id),
    .mismatch_count (mismatches),
    .read_count     (reads_seen)
  );

  // ********************************************************************
  // clocks, window phase and watchdog
  // ********************************************************************

  initial begin
    up_clk = 1'b0;
    forever #4 up_clk = ~up_clk;
  end

  // half period of 0 parks the device clock
  initial begin
    d_clk0 = 1'b0;
    forever begin
      wait (half0 != 0);
      #(half0) d_clk0 = ~d_clk0;
    end
  end

  initial begin
    d_clk1 = 1'b0;
    forever begin
      wait (half1 != 0);
      #(half1) d_clk1 = ~d_clk1;
    end
  end

  // cycles since reset, window ticks land near phase 0
  always @(posedge up_clk or posedge up_rst) begin
    if (up_rst) begin
      cyc <= 0;
    end else begin
      cyc <= cyc + 1;
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("timeout after %0d ns, the tests did not finish", WATCHDOG_NS);
    $display("Simulation failed");
    $finish;
  end

  // ********************************************************************
  // random source and bus tasks
  // ********************************************************************

  // galois form, taps x^32 x^22 x^2 x^1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) begin
      return (s >> 1) ^ 32'h8020_0003;
    end else begin
      return s >> 1;
    end
  endfunction

  task automatic random_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v[i] = lfsr[0];
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic write_reg(input clk_mon_pkg::reg_addr_t addr, input clk_mon_pkg::reg_data_t data);
    logic [31:0] gap;
    int          waited;
    random_bits(2, gap);
    repeat (gap[1:0]) @(posedge up_clk);
    up_wreq  <= 1'b1;
    up_waddr <= addr;
    up_wdata <= data;
    @(posedge up_clk);
    up_wreq <= 1'b0;
    waited = 0;
    do begin
      @(posedge up_clk);
      waited++;
    end while (!up_wack && waited < 4);
    if (!up_wack) begin
      other_errors++;
      $display("no write acknowledge for address 0x%02h", addr);
    end
  endtask

  // expectation travels with the request, the checker compares on the ack
  task automatic read_check(input clk_mon_pkg::reg_addr_t addr, input logic [31:0] lo,
                            input logic [31:0] hi, input logic [127:0] name, input int id);
    logic [31:0] gap;
    int          waited;
    random_bits(2, gap);
    repeat (gap[1:0]) @(posedge up_clk);
    exp_lo   <= lo;
    exp_hi   <= hi;
    exp_name <= name;
    exp_id   <= 8'(id);
    up_rreq  <= 1'b1;
    up_raddr <= addr;
    @(posedge up_clk);
    up_rreq <= 1'b0;
    waited = 0;
    do begin
      @(posedge up_clk);
      waited++;
    end while (!up_rack && waited < 4);
    if (!up_rack) begin
      other_errors++;
      $display("no read acknowledge for address 0x%02h", addr);
    end
  endtask

  task automatic wait_phase(input int phase);
    while ((cyc % WIN_CYCLES) != phase) @(posedge up_clk);
  endtask

  // ********************************************************************
  // one stim row: set clocks and limits, clear, measure, check
  // ********************************************************************

  task automatic run_row(input int r);
    logic [31:0] v [0:COLS-1];
    for (int i = 0; i < COLS; i++) begin
      v[i] = stim_mem[r*COLS+i];
    end
    half0 = int'(v[0]);
    half1 = int'(v[1]);
    write_reg(clk_mon_pkg::ADDR_MIN_BASE, v[2]);
    write_reg(clk_mon_pkg::ADDR_MAX_BASE, v[3]);
    write_reg(clk_mon_pkg::ADDR_MIN_BASE + 8'd1, v[4]);
    write_reg(clk_mon_pkg::ADDR_MAX_BASE + 8'd1, v[5]);
    // window mixing old and new clock is flushed by the clear
    repeat (WIN_CYCLES) @(posedge up_clk);
    wait_phase(CLEAR_PHASE);
    write_reg(clk_mon_pkg::ADDR_STATUS_BASE, 32'h7);
    write_reg(clk_mon_pkg::ADDR_STATUS_BASE + 8'd1, 32'h7);
    read_check(clk_mon_pkg::ADDR_STATUS_BASE, 0, 0, "status_clear", r);
    read_check(clk_mon_pkg::ADDR_STATUS_BASE + 8'd1, 0, 0, "status_clear", r);
    // enough windows for fresh counts and a lost clock to show
    repeat ((LOST_WINDOWS + 1) * WIN_CYCLES) @(posedge up_clk);
    if (v[6] != 0) begin
      read_check(clk_mon_pkg::ADDR_COUNT_BASE, v[6] - v[8], v[6] + v[8], "count_ch0", r);
    end
    if (v[7] != 0) begin
      read_check(clk_mon_pkg::ADDR_COUNT_BASE + 8'd1, v[7] - v[8], v[7] + v[8], "count_ch1", r);
    end
    read_check(clk_mon_pkg::ADDR_STATUS_BASE, v[9], v[9], "status_ch0", r);
    read_check(clk_mon_pkg::ADDR_STATUS_BASE + 8'd1, v[10], v[10], "status_ch1", r);
    // a clock that stays away reports again after the clear
    if (v[9][clk_mon_pkg::FLAG_CLOCK_LOST]) begin
      write_reg(clk_mon_pkg::ADDR_STATUS_BASE, 32'h7);
      read_check(clk_mon_pkg::ADDR_STATUS_BASE, 0, 0, "lost_clear", r);
      repeat (2 * WIN_CYCLES) @(posedge up_clk);
      read_check(clk_mon_pkg::ADDR_STATUS_BASE, v[9], v[9], "lost_return", r);
    end
  endtask

  // ********************************************************************
  // main sequence
  // ********************************************************************

  initial begin
    logic [31:0] val;
    logic        stim_ok;
    up_rst       = 1'b1;
    d_rst        = '1;
    up_wreq      = 1'b0;
    up_waddr     = '0;
    up_wdata     = '0;
    up_rreq      = 1'b0;
    up_raddr     = '0;
    exp_lo       = '0;
    exp_hi       = '0;
    exp_name     = '0;
    exp_id       = '0;
    half0        = 0;
    half1        = 0;
    other_errors = 0;
    lfsr         = 32'd73751;
    $readmemh("verification/clk_mon_stim.txt", stim_mem);
    stim_ok = !$isunknown(stim_mem[NUM_TESTS*COLS-1]);
    if (stim_ok) begin
      half0 = int'(stim_mem[0]);
      half1 = int'(stim_mem[1]);
    end else begin
      other_errors++;
      $display("stimulus file missing or shorter than %0d rows", NUM_TESTS);
    end
    repeat (8) @(posedge up_clk);
    up_rst <= 1'b0;
    d_rst  <= '0;
    @(posedge up_clk);

    // reset values, well before the first window ends
    read_check(clk_mon_pkg::ADDR_VERSION, clk_mon_pkg::CORE_VERSION,
               clk_mon_pkg::CORE_VERSION, "reset_version", 0);
    for (int i = 0; i < NUM_CLKS; i++) begin
      read_check(clk_mon_pkg::ADDR_STATUS_BASE + 8'(i), 0, 0, "reset_status", i);
      read_check(clk_mon_pkg::ADDR_MIN_BASE + 8'(i), 0, 0, "reset_min", i);
      read_check(clk_mon_pkg::ADDR_MAX_BASE + 8'(i), '1, '1, "reset_max", i);
    end
    read_check(8'h3c, 0, 0, "unknown_addr", 0);

    // random limits read back as written
    for (int i = 0; i < NUM_CLKS; i++) begin
      random_bits(32, val);
      write_reg(clk_mon_pkg::ADDR_MIN_BASE + 8'(i), val);
      read_check(clk_mon_pkg::ADDR_MIN_BASE + 8'(i), val, val, "limit_readback", i);
      random_bits(32, val);
      write_reg(clk_mon_pkg::ADDR_MAX_BASE + 8'(i), val);
      read_check(clk_mon_pkg::ADDR_MAX_BASE + 8'(i), val, val, "limit_readback", i);
    end

    if (stim_ok) begin
      for (int r = 0; r < NUM_TESTS; r++) begin
        run_row(r);
      end
    end

    // let the last compare settle in the checker
    repeat (2) @(posedge up_clk);
    $display("closing counts: reads %0d, mismatches %0d, other errors %0d",
             reads_seen, mismatches, other_errors);
    if ((mismatches == 0) && (other_errors == 0)) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
